//--- common/video_pkg.sv
package video_pkg;

    // ====================
    // Colour types
    // ====================

    // Red in [23:16], green in [15:8], blue in [7:0]
    typedef logic [23:0] rgb_t;

    // One palette entry per index
    typedef logic [7:0] pal_index_t;

    // ====================
    // Raster defaults
    // ====================

    // 640x480 at 60 Hz, counted in pixel clocks and lines
    localparam int H_ACTIVE_DEF = 640;
    localparam int H_FRONT_DEF  = 16;
    localparam int H_SYNC_DEF   = 96;
    localparam int H_TOTAL_DEF  = 800;
    localparam int V_ACTIVE_DEF = 480;
    localparam int V_FRONT_DEF  = 10;
    localparam int V_SYNC_DEF   = 2;
    localparam int V_TOTAL_DEF  = 525;

endpackage

//--- common/vram_pkg.sv
package vram_pkg;

    // Each VRAM word packs this many 8-bit palette indices
    localparam int PIX_PER_WORD = 8;

    // Pixel p lives in bits [8p+7:8p], pixel 0 in the low byte
    typedef logic [8*PIX_PER_WORD-1:0] vram_word_t;

    // Word address into VRAM
    localparam int VRAM_ADDR_W = 13;
    typedef logic [VRAM_ADDR_W-1:0] vram_addr_t;

endpackage

//--- src/dual_port_ram.sv
`timescale 1ns/1ns

module dual_port_ram #(
    parameter type elem_t = logic [7:0],
    parameter int  DEPTH  = 256
) (
    input  logic                     clk,
    input  logic                     wren,
    input  logic [$clog2(DEPTH)-1:0] wraddr,
    input  elem_t                    wrdata,
    input  logic [$clog2(DEPTH)-1:0] rdaddr,
    output elem_t                    rddata
);

    elem_t mem [DEPTH];

    // One write port, one read port, read data registered
    always_ff @(posedge clk) begin
        if (wren) begin
            mem[wraddr] <= wrdata;
        end
    end

    // Same-address read during a write returns the old word
    always_ff @(posedge clk) begin
        rddata <= mem[rdaddr];
    end

endmodule

//--- src/video_timer.sv
`timescale 1ns/1ns

module video_timer #(
    parameter int H_ACTIVE = video_pkg::H_ACTIVE_DEF,
    parameter int H_FRONT  = video_pkg::H_FRONT_DEF,
    parameter int H_SYNC   = video_pkg::H_SYNC_DEF,
    parameter int H_TOTAL  = video_pkg::H_TOTAL_DEF,
    parameter int V_ACTIVE = video_pkg::V_ACTIVE_DEF,
    parameter int V_FRONT  = video_pkg::V_FRONT_DEF,
    parameter int V_SYNC   = video_pkg::V_SYNC_DEF,
    parameter int V_TOTAL  = video_pkg::V_TOTAL_DEF
) (
    input  logic                        clk,
    input  logic                        rst,
    output logic [$clog2(H_ACTIVE)-1:0] x,
    output logic                        active,
    output logic                        line_hs,
    output logic                        line_vs,
    output logic                        render_start,
    output logic                        rowram_swap,
    output logic                        vblank_start,
    output vram_pkg::vram_addr_t        next_row,
    output logic                        cpu_wr_busy
);

    import vram_pkg::*;

    localparam int HW = $clog2(H_TOTAL);
    localparam int VW = $clog2(V_TOTAL);
    localparam int XW = $clog2(H_ACTIVE);

    logic [HW-1:0] h_cnt;
    logic [HW-1:0] h_nxt;
    logic [VW-1:0] v_cnt;
    logic [VW-1:0] v_nxt;
    logic [VW-1:0] v_after;
    logic          render_line;

    // Next raster position, and the line that follows it
    always_comb begin
        if (h_cnt == HW'(H_TOTAL - 1)) begin
            h_nxt = '0;
            v_nxt = (v_cnt == VW'(V_TOTAL - 1)) ? '0 : v_cnt + 1'b1;
        end else begin
            h_nxt = h_cnt + 1'b1;
            v_nxt = v_cnt;
        end
        v_after     = (v_nxt == VW'(V_TOTAL - 1)) ? '0 : v_nxt + 1'b1;
        render_line = (v_after < V_ACTIVE);
    end

    // ====================
    // Counters and decode
    // ====================

    // Outputs are decoded from the next position so they line up with the counters
    always_ff @(posedge clk) begin
        if (rst) begin
            // Park on the first blank line, outside the busy window
            h_cnt        <= '0;
            v_cnt        <= VW'(V_ACTIVE);
            x            <= '0;
            active       <= 1'b0;
            line_hs      <= 1'b0;
            line_vs      <= 1'b0;
            render_start <= 1'b0;
            rowram_swap  <= 1'b0;
            vblank_start <= 1'b0;
            next_row     <= '0;
            cpu_wr_busy  <= 1'b0;
        end else begin
            h_cnt        <= h_nxt;
            v_cnt        <= v_nxt;
            x            <= h_nxt[XW-1:0];
            active       <= (h_nxt < H_ACTIVE) && (v_nxt < V_ACTIVE);
            line_hs      <= (h_nxt >= H_ACTIVE + H_FRONT) &&
                            (h_nxt < H_ACTIVE + H_FRONT + H_SYNC);
            line_vs      <= (v_nxt >= V_ACTIVE + V_FRONT) &&
                            (v_nxt < V_ACTIVE + V_FRONT + V_SYNC);
            // Render the following line while this one is shown
            render_start <= (h_nxt == '0) && render_line;
            rowram_swap  <= (h_nxt == HW'(H_TOTAL - 1)) && render_line;
            vblank_start <= (h_nxt == '0) && (v_nxt == VW'(V_ACTIVE));
            next_row     <= vram_addr_t'(v_after);
            // Last blank line renders row 0, so it counts as busy too
            cpu_wr_busy  <= (v_nxt == VW'(V_TOTAL - 1)) || (v_nxt < V_ACTIVE);
        end
    end

endmodule

//--- ppu/ppu_fsm.sv
`timescale 1ns/1ns

module ppu_fsm #(
    parameter int H_ACTIVE = video_pkg::H_ACTIVE_DEF
) (
    input  logic                                                 clk,
    input  logic                                                 rst,
    input  logic                                                 render_start,
    input  logic                                                 vblank_start,
    input  vram_pkg::vram_addr_t                                 next_row,
    input  logic [$clog2(H_ACTIVE)-1:0]                          cpu_scroll_x,
    output vram_pkg::vram_addr_t                                 vram_rdaddr,
    input  vram_pkg::vram_word_t                                 vram_rddata,
    output logic                                                 row_wren,
    output logic [$clog2(H_ACTIVE / vram_pkg::PIX_PER_WORD)-1:0] row_wrindex,
    output vram_pkg::vram_word_t                                 row_wrdata,
    output logic [$clog2(H_ACTIVE)-1:0]                          scroll_x,
    output logic                                                 cpu_vram_irq
);

    import vram_pkg::*;

    localparam int WORDS = H_ACTIVE / PIX_PER_WORD;
    localparam int IW    = $clog2(WORDS);
    localparam int XW    = $clog2(H_ACTIVE);

    typedef enum logic [1:0] {
        S_IDLE,
        S_READ,
        S_DRAIN
    } state_t;

    state_t        state;
    logic [IW-1:0] word_cnt;
    logic [IW-1:0] index_q;
    logic          rd_q;
    vram_addr_t    row_base;

    // ====================
    // Line render
    // ====================

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= S_IDLE;
            word_cnt <= '0;
            rd_q     <= 1'b0;
        end else begin
            rd_q <= (state == S_READ);
            case (state)
                S_IDLE: begin
                    if (render_start) begin
                        state    <= S_READ;
                        word_cnt <= '0;
                    end
                end
                S_READ: begin
                    if (word_cnt == IW'(WORDS - 1)) begin
                        state <= S_DRAIN;
                    end else begin
                        word_cnt <= word_cnt + 1'b1;
                    end
                end
                // Last word is still in flight from VRAM
                S_DRAIN: state <= S_IDLE;
                default: state <= S_IDLE;
            endcase
        end
    end

    // Start of the row in VRAM, and the index that matches the returning word
    always_ff @(posedge clk) begin
        if (render_start) begin
            row_base <= vram_addr_t'(next_row * WORDS);
        end
        index_q <= word_cnt;
    end

    assign vram_rdaddr = row_base + vram_addr_t'(word_cnt);
    assign row_wren    = rd_q;
    assign row_wrindex = index_q;
    assign row_wrdata  = vram_rddata;

    // ====================
    // Frame registers
    // ====================

    // Scroll taken once per frame, wrapped into the visible width
    always_ff @(posedge clk) begin
        if (rst) begin
            scroll_x     <= '0;
            cpu_vram_irq <= 1'b0;
        end else begin
            cpu_vram_irq <= vblank_start;
            if (vblank_start) begin
                if (cpu_scroll_x >= H_ACTIVE) begin
                    scroll_x <= cpu_scroll_x - XW'(H_ACTIVE);
                end else begin
                    scroll_x <= cpu_scroll_x;
                end
            end
        end
    end

endmodule

//--- ppu/row_buffer.sv
`timescale 1ns/1ns

module row_buffer #(
    parameter int WORDS = video_pkg::H_ACTIVE_DEF / vram_pkg::PIX_PER_WORD
) (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     rowram_swap,
    input  logic                     wren,
    input  logic [$clog2(WORDS)-1:0] wrindex,
    input  vram_pkg::vram_word_t     wrdata,
    input  logic [$clog2(WORDS)-1:0] rdindex,
    output vram_pkg::vram_word_t     rddata
);

    import vram_pkg::*;

    localparam int IW = $clog2(WORDS);

    // Two banks, each rounded up to a power of two so the bank bit can lead
    localparam int DEPTH = 2 * (1 << IW);

    logic front_bank;

    always_ff @(posedge clk) begin
        if (rst) begin
            front_bank <= 1'b0;
        end else if (rowram_swap) begin
            front_bank <= ~front_bank;
        end
    end

    // Renderer fills the hidden bank while the front one is scanned out
    dual_port_ram #(
        .elem_t (vram_word_t),
        .DEPTH  (DEPTH)
    ) i_row_ram (
        .clk    (clk),
        .wren   (wren),
        .wraddr ({~front_bank, wrindex}),
        .wrdata (wrdata),
        .rdaddr ({front_bank, rdindex}),
        .rddata (rddata)
    );

endmodule

//--- ppu/pixel_out.sv
`timescale 1ns/1ns

module pixel_out #(
    parameter int H_ACTIVE = video_pkg::H_ACTIVE_DEF
) (
    input  logic                                                 clk,
    input  logic                                                 rst,
    input  logic [$clog2(H_ACTIVE)-1:0]                          x,
    input  logic                                                 active,
    input  logic                                                 line_hs,
    input  logic                                                 line_vs,
    input  logic [$clog2(H_ACTIVE)-1:0]                          scroll_x,
    output logic [$clog2(H_ACTIVE / vram_pkg::PIX_PER_WORD)-1:0] row_rdindex,
    input  vram_pkg::vram_word_t                                 row_rddata,
    output video_pkg::pal_index_t                                pal_rdaddr,
    input  video_pkg::rgb_t                                      pal_rddata,
    output video_pkg::rgb_t                                      rgb,
    output logic                                                 de,
    output logic                                                 hs,
    output logic                                                 vs
);

    import video_pkg::*;
    import vram_pkg::*;

    localparam int XW = $clog2(H_ACTIVE);
    localparam int IW = $clog2(H_ACTIVE / PIX_PER_WORD);
    localparam int SW = $clog2(PIX_PER_WORD);

    logic [XW:0]   sum;
    logic [XW-1:0] sx;
    logic [SW-1:0] sel_q;
    logic          active_q;
    logic          hs_q;
    logic          vs_q;

    // Stage 0: scrolled column, wrapped at the row width
    always_comb begin
        sum = {1'b0, x} + {1'b0, scroll_x};
        if (sum >= H_ACTIVE) begin
            sx = XW'(sum - H_ACTIVE);
        end else begin
            sx = sum[XW-1:0];
        end
    end

    assign row_rdindex = IW'(sx >> SW);

    // Stage 1: byte select once the row word is back
    always_ff @(posedge clk) begin
        sel_q <= sx[SW-1:0];
    end

    assign pal_rdaddr = row_rddata[8*sel_q +: 8];

    // Stage 2: palette colour, controls delayed to match
    always_ff @(posedge clk) begin
        if (rst) begin
            active_q <= 1'b0;
            hs_q     <= 1'b0;
            vs_q     <= 1'b0;
            de       <= 1'b0;
            hs       <= 1'b0;
            vs       <= 1'b0;
        end else begin
            active_q <= active;
            hs_q     <= line_hs;
            vs_q     <= line_vs;
            de       <= active_q;
            hs       <= hs_q;
            vs       <= vs_q;
        end
    end

    // Black outside the visible area
    assign rgb = de ? pal_rddata : rgb_t'(0);

endmodule

//--- src/console_video.sv
`timescale 1ns/1ns

module console_video #(
    parameter int H_ACTIVE = video_pkg::H_ACTIVE_DEF,
    parameter int H_FRONT  = video_pkg::H_FRONT_DEF,
    parameter int H_SYNC   = video_pkg::H_SYNC_DEF,
    parameter int H_TOTAL  = video_pkg::H_TOTAL_DEF,
    parameter int V_ACTIVE = video_pkg::V_ACTIVE_DEF,
    parameter int V_FRONT  = video_pkg::V_FRONT_DEF,
    parameter int V_SYNC   = video_pkg::V_SYNC_DEF,
    parameter int V_TOTAL  = video_pkg::V_TOTAL_DEF
) (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        cpu_vram_wren,
    input  vram_pkg::vram_addr_t        cpu_vram_addr,
    input  vram_pkg::vram_word_t        cpu_vram_data,
    input  logic                        cpu_pal_wren,
    input  video_pkg::pal_index_t       cpu_pal_addr,
    input  video_pkg::rgb_t             cpu_pal_data,
    input  logic [$clog2(H_ACTIVE)-1:0] cpu_scroll_x,
    output logic                        cpu_wr_busy,
    output logic                        cpu_vram_irq,
    output video_pkg::rgb_t             rgb,
    output logic                        de,
    output logic                        hs,
    output logic                        vs
);

    import video_pkg::*;
    import vram_pkg::*;

    localparam int WORDS = H_ACTIVE / PIX_PER_WORD;
    localparam int XW    = $clog2(H_ACTIVE);
    localparam int IW    = $clog2(WORDS);

    // ====================
    // Interconnect
    // ====================

    // Timer to renderer and scan-out
    logic [XW-1:0] x;
    logic          active;
    logic          line_hs;
    logic          line_vs;
    logic          render_start;
    logic          rowram_swap;
    logic          vblank_start;
    vram_addr_t    next_row;

    // Renderer side
    vram_addr_t    vram_rdaddr;
    vram_word_t    vram_rddata;
    logic          row_wren;
    logic [IW-1:0] row_wrindex;
    vram_word_t    row_wrdata;
    logic [XW-1:0] scroll_x;

    // Scan-out side
    logic [IW-1:0] row_rdindex;
    vram_word_t    row_rddata;
    pal_index_t    pal_rdaddr;
    rgb_t          pal_rddata;

    // CPU writes only land outside the busy window
    logic          vram_wren_ok;
    logic          pal_wren_ok;

    assign vram_wren_ok = cpu_vram_wren & ~cpu_wr_busy;
    assign pal_wren_ok  = cpu_pal_wren & ~cpu_wr_busy;

    // ====================
    // Submodules
    // ====================

    video_timer #(
        .H_ACTIVE (H_ACTIVE),
        .H_FRONT  (H_FRONT),
        .H_SYNC   (H_SYNC),
        .H_TOTAL  (H_TOTAL),
        .V_ACTIVE (V_ACTIVE),
        .V_FRONT  (V_FRONT),
        .V_SYNC   (V_SYNC),
        .V_TOTAL  (V_TOTAL)
    ) i_video_timer (
        .clk          (clk),
        .rst          (rst),
        .x            (x),
        .active       (active),
        .line_hs      (line_hs),
        .line_vs      (line_vs),
        .render_start (render_start),
        .rowram_swap  (rowram_swap),
        .vblank_start (vblank_start),
        .next_row     (next_row),
        .cpu_wr_busy  (cpu_wr_busy)
    );

    dual_port_ram #(
        .elem_t (vram_word_t),
        .DEPTH  (2 ** VRAM_ADDR_W)
    ) i_vram (
        .clk    (clk),
        .wren   (vram_wren_ok),
        .wraddr (cpu_vram_addr),
        .wrdata (cpu_vram_data),
        .rdaddr (vram_rdaddr),
        .rddata (vram_rddata)
    );

    dual_port_ram #(
        .elem_t (rgb_t),
        .DEPTH  (2 ** $bits(pal_index_t))
    ) i_palette (
        .clk    (clk),
        .wren   (pal_wren_ok),
        .wraddr (cpu_pal_addr),
        .wrdata (cpu_pal_data),
        .rdaddr (pal_rdaddr),
        .rddata (pal_rddata)
    );

    ppu_fsm #(
        .H_ACTIVE (H_ACTIVE)
    ) i_ppu_fsm (
        .clk          (clk),
        .rst          (rst),
        .render_start (render_start),
        .vblank_start (vblank_start),
        .next_row     (next_row),
        .cpu_scroll_x (cpu_scroll_x),
        .vram_rdaddr  (vram_rdaddr),
        .vram_rddata  (vram_rddata),
        .row_wren     (row_wren),
        .row_wrindex  (row_wrindex),
        .row_wrdata   (row_wrdata),
        .scroll_x     (scroll_x),
        .cpu_vram_irq (cpu_vram_irq)
    );

    row_buffer #(
        .WORDS (WORDS)
    ) i_row_buffer (
        .clk         (clk),
        .rst         (rst),
        .rowram_swap (rowram_swap),
        .wren        (row_wren),
        .wrindex     (row_wrindex),
        .wrdata      (row_wrdata),
        .rdindex     (row_rdindex),
        .rddata      (row_rddata)
    );

    pixel_out #(
        .H_ACTIVE (H_ACTIVE)
    ) i_pixel_out (
        .clk         (clk),
        .rst         (rst),
        .x           (x),
        .active      (active),
        .line_hs     (line_hs),
        .line_vs     (line_vs),
        .scroll_x    (scroll_x),
        .row_rdindex (row_rdindex),
        .row_rddata  (row_rddata),
        .pal_rdaddr  (pal_rdaddr),
        .pal_rddata  (pal_rddata),
        .rgb         (rgb),
        .de          (de),
        .hs          (hs),
        .vs          (vs)
    );

endmodule

//--- test/tb_console_video.sv
`timescale 1ns/1ns

module tb_console_video;

    import video_pkg::*;
    import vram_pkg::*;

    localparam int H_ACTIVE = 32;
    localparam int H_FRONT  = 4;
    localparam int H_SYNC   = 4;
    localparam int H_TOTAL  = 48;
    localparam int V_ACTIVE = 8;
    localparam int V_FRONT  = 2;
    localparam int V_SYNC   = 2;
    localparam int V_TOTAL  = 16;
    localparam int WORDS    = H_ACTIVE / PIX_PER_WORD;
    localparam int XW       = $clog2(H_ACTIVE);
    localparam int FRAME    = H_TOTAL * V_TOTAL;

    logic          clk;
    logic          rst;
    logic          cpu_vram_wren;
    vram_addr_t    cpu_vram_addr;
    vram_word_t    cpu_vram_data;
    logic          cpu_pal_wren;
    pal_index_t    cpu_pal_addr;
    rgb_t          cpu_pal_data;
    logic [XW-1:0] cpu_scroll_x;
    logic          cpu_wr_busy;
    logic          cpu_vram_irq;
    rgb_t          rgb;
    logic          de;
    logic          hs;
    logic          vs;

    // Memory contents as the CPU managed to write them
    vram_word_t vram_model [WORDS * V_ACTIVE];
    rgb_t       pal_model [256];
    bit [31:0]  lfsr_state;
    bit         armed = 1'b0;
    int         frames_checked = 0;
    string      test_name = "reset";

    console_video #(
        .H_ACTIVE (H_ACTIVE),
        .H_FRONT  (H_FRONT),
        .H_SYNC   (H_SYNC),
        .H_TOTAL  (H_TOTAL),
        .V_ACTIVE (V_ACTIVE),
        .V_FRONT  (V_FRONT),
        .V_SYNC   (V_SYNC),
        .V_TOTAL  (V_TOTAL)
    ) i_console_video (
        .clk           (clk),
        .rst           (rst),
        .cpu_vram_wren (cpu_vram_wren),
        .cpu_vram_addr (cpu_vram_addr),
        .cpu_vram_data (cpu_vram_data),
        .cpu_pal_wren  (cpu_pal_wren),
        .cpu_pal_addr  (cpu_pal_addr),
        .cpu_pal_data  (cpu_pal_data),
        .cpu_scroll_x  (cpu_scroll_x),
        .cpu_wr_busy   (cpu_wr_busy),
        .cpu_vram_irq  (cpu_vram_irq),
        .rgb           (rgb),
        .de            (de),
        .hs            (hs),
        .vs            (vs)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // ====================
    // Helpers
    // ====================

    // Taps 32, 22, 2, 1
    function automatic bit [31:0] lfsr_next(bit [31:0] s);
        bit fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    function automatic logic [63:0] random_bits(int n);
        logic [63:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[62:0], lfsr_state[0]};
        end
        return v;
    endfunction

    // Colour expected at column px of row py under the given scroll
    function automatic rgb_t expected_rgb(int px, int py, int scroll);
        int         sx;
        vram_word_t word;
        pal_index_t idx;
        sx   = (px + scroll) % H_ACTIVE;
        word = vram_model[py * WORDS + sx / PIX_PER_WORD];
        idx  = word[8 * (sx % PIX_PER_WORD) +: 8];
        return pal_model[idx];
    endfunction

    task automatic abort_run(string why);
        $display("%s", why);
        $display("*** FAILED ***");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic check_rgb(string name, rgb_t exp, rgb_t act);
        if (act !== exp) begin
            abort_run($sformatf("FAIL %s expected %h actual %h", name, exp, act));
        end
    endtask

    task automatic check_count(string name, int exp, int act);
        if (act != exp) begin
            abort_run($sformatf("FAIL %s expected %0d actual %0d", name, exp, act));
        end
    endtask

    task automatic check_level(string name, logic exp, logic act);
        if (act !== exp) begin
            abort_run($sformatf("FAIL %s expected %b actual %b", name, exp, act));
        end
    endtask

    task automatic wait_busy(logic level);
        int guard;
        guard = 0;
        while (cpu_wr_busy !== level) begin
            @(posedge clk);
            #1;
            guard++;
            if (guard > 2 * FRAME) begin
                abort_run("Timed out waiting for cpu_wr_busy to change");
            end
        end
    endtask

    task automatic wait_frames(int n);
        int target;
        int guard;
        target = frames_checked + n;
        guard  = 0;
        while (frames_checked < target) begin
            @(posedge clk);
            #1;
            guard++;
            if (guard > (n + 2) * FRAME) begin
                abort_run("Timed out waiting for checked frames");
            end
        end
    endtask

    // Writes land one per cycle, only while the port is open
    task automatic fill_memories();
        int vi;
        int pi;
        int guard;
        vi    = 0;
        pi    = 0;
        guard = 0;
        while (vi < WORDS * V_ACTIVE || pi < 256) begin
            cpu_vram_wren = 1'b0;
            cpu_pal_wren  = 1'b0;
            if (!cpu_wr_busy && vi < WORDS * V_ACTIVE) begin
                cpu_vram_wren  = 1'b1;
                cpu_vram_addr  = vram_addr_t'(vi);
                cpu_vram_data  = random_bits(64);
                vram_model[vi] = cpu_vram_data;
                vi++;
            end
            if (!cpu_wr_busy && pi < 256) begin
                cpu_pal_wren  = 1'b1;
                cpu_pal_addr  = pal_index_t'(pi);
                cpu_pal_data  = rgb_t'(random_bits(24));
                pal_model[pi] = cpu_pal_data;
                pi++;
            end
            guard++;
            if (guard > 4 * FRAME) begin
                abort_run("Timed out filling VRAM and palette");
            end
            @(posedge clk);
            #1;
        end
        cpu_vram_wren = 1'b0;
        cpu_pal_wren  = 1'b0;
    endtask

    // ====================
    // Compare process
    // ====================

    initial begin
        logic prev_de;
        logic prev_vs;
        logic prev_hs;
        logic prev_busy;
        logic prev_irq;
        int   px;
        int   row;
        int   vs_falls;
        int   vs_pulses;
        int   irq_pulses;
        int   hs_pulses;
        int   hs_width;
        int   since_de;
        bit   de_line;
        int   busy_age;
        int   scroll_prev;
        int   frame_scroll;
        bit   frame_checked;
        forever begin
            @(negedge clk);
            if (rst) begin
                prev_de       = 1'b0;
                prev_vs       = 1'b0;
                prev_hs       = 1'b0;
                prev_busy     = 1'b0;
                prev_irq      = 1'b0;
                px            = 0;
                row           = 0;
                vs_falls      = 0;
                vs_pulses     = 0;
                irq_pulses    = 0;
                hs_pulses     = 0;
                hs_width      = 0;
                since_de      = 0;
                de_line       = 1'b0;
                busy_age      = 0;
                scroll_prev   = int'(cpu_scroll_x);
                frame_scroll  = 0;
                frame_checked = 1'b0;
            end else begin
                if (de && !prev_de) begin
                    px = 0;
                end
                if (de) begin
                    if (frame_checked) begin
                        check_rgb($sformatf("%s x%0d y%0d", test_name, px, row),
                                  expected_rgb(px, row, frame_scroll), rgb);
                    end
                    px++;
                end
                if (!de && prev_de) begin
                    check_count("pixels per line", H_ACTIVE, px);
                    row++;
                    since_de = 0;
                    de_line  = 1'b1;
                end else begin
                    since_de++;
                end
                // Sync starts a front porch after the visible pixels
                if (hs && !prev_hs) begin
                    hs_pulses++;
                    hs_width = 0;
                    if (de_line) begin
                        check_count("hs offset after de", H_FRONT, since_de);
                    end
                    de_line = 1'b0;
                end
                if (hs) begin
                    hs_width++;
                end
                if (!hs && prev_hs) begin
                    check_count("hs pulse width", H_SYNC, hs_width);
                end
                if (vs && !prev_vs) begin
                    vs_pulses++;
                end
                if (!cpu_wr_busy && prev_busy) begin
                    busy_age = 0;
                end else begin
                    busy_age++;
                end
                // Scroll seen by the DUT at the vblank_start edge
                if (cpu_vram_irq && !prev_irq) begin
                    check_count("irq cycles after busy fall", 1, busy_age);
                    irq_pulses++;
                    frame_scroll = scroll_prev;
                end
                if (cpu_vram_irq) begin
                    check_level("irq pulse width", 1'b0, prev_irq);
                end
                if (!vs && prev_vs) begin
                    vs_falls++;
                    if (vs_falls >= 2) begin
                        check_count("lines per frame", V_ACTIVE, row);
                        check_count("vs pulses per frame", 1, vs_pulses);
                        check_count("irq pulses per frame", 1, irq_pulses);
                        check_count("hs pulses per frame", V_TOTAL, hs_pulses);
                        if (frame_checked) begin
                            frames_checked++;
                        end
                    end
                    row           = 0;
                    vs_pulses     = 0;
                    irq_pulses    = 0;
                    hs_pulses     = 0;
                    frame_checked = armed;
                end
                prev_de     = de;
                prev_vs     = vs;
                prev_hs     = hs;
                prev_busy   = cpu_wr_busy;
                prev_irq    = cpu_vram_irq;
                scroll_prev = int'(cpu_scroll_x);
            end
        end
    end

    // ====================
    // Stimulus
    // ====================

    initial begin
        logic [XW-1:0] new_scroll;
        rst           = 1'b1;
        cpu_vram_wren = 1'b0;
        cpu_vram_addr = '0;
        cpu_vram_data = '0;
        cpu_pal_wren  = 1'b0;
        cpu_pal_addr  = '0;
        cpu_pal_data  = '0;
        cpu_scroll_x  = '0;
        lfsr_state    = 32'h7d212249;
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;

        check_level("reset de", 1'b0, de);
        check_level("reset hs", 1'b0, hs);
        check_level("reset vs", 1'b0, vs);
        check_level("reset cpu_vram_irq", 1'b0, cpu_vram_irq);
        check_level("reset cpu_wr_busy", 1'b0, cpu_wr_busy);

        test_name = "frame";
        fill_memories();
        armed = 1'b1;
        wait_frames(2);

        // New scroll takes effect from the next vblank_start
        test_name = "scroll";
        for (int i = 0; i < 2; i++) begin
            wait_busy(1'b0);
            new_scroll = XW'(random_bits(XW));
            if (new_scroll == '0) begin
                new_scroll = XW'(H_ACTIVE - 1);
            end
            cpu_scroll_x = new_scroll;
            wait_frames(3);
        end

        // Writes into the busy window must be dropped
        test_name = "busy writes";
        wait_busy(1'b1);
        for (int i = 0; i < 40; i++) begin
            cpu_vram_wren = cpu_wr_busy;
            cpu_pal_wren  = cpu_wr_busy;
            cpu_vram_addr = vram_addr_t'(random_bits(5));
            cpu_vram_data = random_bits(64);
            cpu_pal_addr  = pal_index_t'(random_bits(8));
            cpu_pal_data  = rgb_t'(random_bits(24));
            @(posedge clk);
            #1;
        end
        cpu_vram_wren = 1'b0;
        cpu_pal_wren  = 1'b0;
        wait_frames(2);

        $display("*** PASSED ***");
        $finish;
    end

endmodule

//--- verilog.f
common/video_pkg.sv
common/vram_pkg.sv
src/dual_port_ram.sv
src/video_timer.sv
ppu/ppu_fsm.sv
ppu/row_buffer.sv
ppu/pixel_out.sv
src/console_video.sv
test/tb_console_video.sv

//--- Makefile
VERILATOR := verilator
TOP       := tb_console_video
FILELIST  := verilog.f
BUILD_DIR := obj_dir
FLAGS     := --binary --timing
LINTFLAGS := --lint-only --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
